// File: Bender.yml
package:
  name: armCore

sources:
  - include_dirs:
      - source
    files:
      - source/isaPkg.sv
      - source/pipePkg.sv
      - source/stageIf.sv
      - source/fetchStage.sv
      - source/decodeStage.sv
      - source/hazardUnit.sv
      - source/executeStage.sv
      - source/memWriteback.sv
      - source/armCore.sv
  - target: test
    files:
      - bench/armCoreTb.sv

// File: armCore.f
+incdir+source
source/isaPkg.sv
source/pipePkg.sv
source/stageIf.sv
source/fetchStage.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/memWriteback.sv
source/armCore.sv
bench/armCoreTb.sv

// File: bench/armCoreTb.sv
/*
 * Testbench for the pipelined ARM subset core
 * Memory models, an instruction encoder and directed program tests
 */
module armCoreTb import isaPkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam word_t SENTINEL_ADDR  = 32'h0000_00FC;
   localparam int    TIMEOUT_CYCLES = 200;

   logic  clk = 1'b0;
   logic  reset;
   word_t pc;
   word_t instr;
   logic  memWrite;
   word_t aluOut;
   word_t writeData;
   word_t readData;

   word_t instrMem [256];
   word_t dataMem [256];
   word_t storeAddrQ [$];
   word_t storeDataQ [$];
   logic  sentinelSeen;
   word_t regModel [16];   // Expected register contents
   word_t lfsr;
   int    progLen;
   int    errorCount;
   int    testCount;
   int    failedTests;

   armCore u_dut (
      .clk       (clk),
      .reset     (reset),
      .pc        (pc),
      .instr     (instr),
      .memWrite  (memWrite),
      .aluOut    (aluOut),
      .writeData (writeData),
      .readData  (readData)
   );

   always #10 clk = ~clk;

   // Both memories answer in the same cycle
   assign instr    = instrMem[pc[9:2]];
   assign readData = dataMem[aluOut[9:2]];

   always @(posedge clk)
   begin
      if (memWrite)
      begin
         dataMem[aluOut[9:2]] <= writeData;
         storeAddrQ.push_back(aluOut);
         storeDataQ.push_back(writeData);
         if (aluOut == SENTINEL_ADDR)
            sentinelSeen <= 1'b1;   // Program reached its last store
      end
   end

   // Taps 32, 22, 2, 1
   function automatic logic lfsrStep();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic word_t randBits(int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], lfsrStep()};
      return v;
   endfunction

   function automatic logic [3:0] dpOpcode(aluOp_t op);
      case (op)
         ALU_ADD: return 4'b0100;
         ALU_SUB: return 4'b0010;
         ALU_AND: return 4'b0000;
         default: return 4'b1100;
      endcase
   endfunction

   function automatic word_t dataProcImm(cond_t c, aluOp_t op, logic s, regAddr_t rd,
                                         regAddr_t rn, logic [7:0] imm);
      return {c, 2'b00, 1'b1, dpOpcode(op), s, rn, rd, 4'h0, imm};
   endfunction

   function automatic word_t dataProcReg(cond_t c, aluOp_t op, logic s, regAddr_t rd,
                                         regAddr_t rn, regAddr_t rm);
      return {c, 2'b00, 1'b0, dpOpcode(op), s, rn, rd, 8'h00, rm};
   endfunction

   // Pre-indexed with the offset added and no writeback
   function automatic word_t memAccess(logic load, regAddr_t rd, regAddr_t rn,
                                       logic [11:0] offset);
      return {COND_AL, 2'b01, 1'b0, 4'b1100, load, rn, rd, offset};
   endfunction

   function automatic word_t branchTo(cond_t c, int fromIdx, int toIdx);
      int off;
      off = toIdx - fromIdx - 2;   // R15 is two words ahead
      return {c, 4'b1010, off[23:0]};
   endfunction

   function automatic word_t aluModel(aluOp_t op, word_t a, word_t b);
      case (op)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_AND: return a & b;
         default: return a | b;
      endcase
   endfunction

   // Condition outcome after SUBS of a and b from the comparison it stands for
   function automatic logic condAfterSub(int k, word_t a, word_t b);
      word_t d;
      logic  ovf;
      d   = a - b;
      ovf = (a[31] != b[31]) && (d[31] != a[31]);
      case (k)
         0:       return a == b;
         1:       return a != b;
         2:       return a >= b;
         3:       return a < b;
         4:       return d[31];
         5:       return !d[31];
         6:       return ovf;
         7:       return !ovf;
         8:       return a > b;
         9:       return a <= b;
         10:      return $signed(a) >= $signed(b);
         11:      return $signed(a) < $signed(b);
         12:      return $signed(a) > $signed(b);
         13:      return $signed(a) <= $signed(b);
         default: return 1'b1;
      endcase
   endfunction

   task automatic emit(word_t w);
      instrMem[progLen] = w;
      progLen++;
   endtask

   task automatic emitZero(regAddr_t rd);
      emit(dataProcReg(COND_AL, ALU_SUB, 1'b0, rd, 15, 15));   // PC minus PC
      regModel[rd] = '0;
   endtask

   task automatic emitDpImm(aluOp_t op, regAddr_t rd, regAddr_t rn, logic [7:0] imm);
      emit(dataProcImm(COND_AL, op, 1'b0, rd, rn, imm));
      regModel[rd] = aluModel(op, regModel[rn], {24'b0, imm});
   endtask

   task automatic emitDpReg(aluOp_t op, regAddr_t rd, regAddr_t rn, regAddr_t rm);
      emit(dataProcReg(COND_AL, op, 1'b0, rd, rn, rm));
      regModel[rd] = aluModel(op, regModel[rn], regModel[rm]);
   endtask

   task automatic checkWord(word_t got, word_t exp, string what);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
         errorCount++;
      end
   endtask

   task automatic checkFlags(flags_t got, flags_t exp, string what);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s nzcv got %b, expected %b", $time, what, got, exp);
         errorCount++;
      end
   endtask

   task automatic findStore(word_t addr, output word_t data, output logic found);
      found = 1'b0;
      data  = 'x;
      foreach (storeAddrQ[i])
         if (storeAddrQ[i] == addr)
         begin
            found = 1'b1;
            data  = storeDataQ[i];
         end
   endtask

   task automatic checkStore(word_t addr, word_t exp, string what);
      word_t data;
      logic  found;
      findStore(addr, data, found);
      if (!found)
      begin
         $display("%s: no store to address %h was seen", what, addr);
         errorCount++;
      end
      else
         checkWord(data, exp, what);
   endtask

   // Holds the core in reset while a new program is loaded
   task automatic beginTest();
      @(posedge clk);
      reset <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < 256; i++)
         instrMem[i] = {4'hF, 28'(i * 4)};   // Cond 1111 is a bubble
      storeAddrQ.delete();
      storeDataQ.delete();
      sentinelSeen = 1'b0;
      progLen      = 0;
   endtask

   task automatic runProgram(string name);
      int cycles;
      repeat (3) @(posedge clk);
      checkWord(pc, '0, "pc in reset");   // Fetch starts at address 0
      reset  <= 1'b0;
      cycles = 0;
      while (!sentinelSeen && cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      if (!sentinelSeen)
      begin
         $display("%s: the final store to %h never arrived within %0d cycles",
                  name, SENTINEL_ADDR, TIMEOUT_CYCLES);
         errorCount++;
      end
   endtask

   task automatic finishTest(string name, int errorsBefore);
      testCount++;
      if (errorCount == errorsBefore)
         $display("%s: ok", name);
      else
      begin
         failedTests++;
         $display("%s: %0d errors", name, errorCount - errorsBefore);
      end
   endtask

   task automatic testArith();
      int startErr;
      startErr = errorCount;
      beginTest();
      emitZero(0);
      emitDpImm(ALU_ADD, 1, 0, 8'hC3);
      emitDpImm(ALU_ADD, 2, 0, 8'h5E);
      emitDpReg(ALU_ADD, 3, 1, 2);   // Back to back so operands are forwarded
      emitDpReg(ALU_SUB, 4, 1, 3);
      emitDpReg(ALU_AND, 5, 4, 3);
      emitDpReg(ALU_ORR, 6, 5, 2);
      emitDpReg(ALU_SUB, 7, 6, 4);
      for (int r = 7; r >= 3; r--)
         emit(memAccess(1'b0, r, 0, 12'(4 * (r - 3))));
      emit(memAccess(1'b0, 0, 0, 12'hFC));
      runProgram("arith and logic");
      for (int r = 3; r <= 7; r++)
         checkStore(4 * (r - 3), regModel[r], $sformatf("R%0d result", r));
      finishTest("arith and logic", startErr);
   endtask

   task automatic testLoadUse();
      int    startErr;
      word_t loadVal;
      startErr = errorCount;
      loadVal  = randBits(32);
      beginTest();
      dataMem[(32'h80 + 32'h24) >> 2] = loadVal;
      emitZero(0);
      emitDpImm(ALU_ADD, 1, 0, 8'h80);
      emit(memAccess(1'b1, 2, 1, 12'h024));
      emit(dataProcImm(COND_AL, ALU_ADD, 1'b0, 3, 2, 8'h5B));   // Needs the load result
      emit(memAccess(1'b0, 3, 1, 12'h030));
      emit(memAccess(1'b0, 3, 0, 12'hFC));
      runProgram("load use");
      if (storeAddrQ.size() < 2)
      begin
         $display("load use: expected two stores, saw %0d", storeAddrQ.size());
         errorCount++;
      end
      else
      begin
         checkWord(storeAddrQ[0], 32'hB0, "store address");
         checkWord(storeDataQ[0], loadVal + 32'h5B, "loaded value plus operand");
      end
      finishTest("load use", startErr);
   endtask

   task automatic testConditions(word_t a, word_t b, string name);
      int          startErr;
      word_t       lowMask;
      word_t       highMask;
      logic        foundLow;
      logic        foundHigh;
      logic [14:0] expMask;
      word_t       gotMask;
      flags_t      gotFlags;
      flags_t      expFlags;
      word_t       diff;
      startErr = errorCount;
      beginTest();
      dataMem[16] = a;
      dataMem[17] = b;
      emitZero(0);
      emit(memAccess(1'b1, 1, 0, 12'h040));
      emit(memAccess(1'b1, 2, 0, 12'h044));
      emitZero(4);
      emitZero(5);
      emit(dataProcReg(COND_AL, ALU_SUB, 1'b1, 3, 1, 2));   // SUBS sets all flags
      for (int k = 0; k < 15; k++)
      begin
         if (k < 8)
            emit(dataProcImm(cond_t'(k), ALU_ADD, 1'b0, 4, 4, 8'(1 << k)));
         else
            emit(dataProcImm(cond_t'(k), ALU_ADD, 1'b0, 5, 5, 8'(1 << (k - 8))));
      end
      emit(memAccess(1'b0, 4, 0, 12'h050));
      emit(memAccess(1'b0, 5, 0, 12'h054));
      emit(memAccess(1'b0, 3, 0, 12'h058));
      emit(memAccess(1'b0, 0, 0, 12'hFC));
      runProgram(name);

      diff = a - b;
      for (int k = 0; k < 15; k++)
         expMask[k] = condAfterSub(k, a, b);
      expFlags.n = diff[31];
      expFlags.z = (diff == '0);
      expFlags.c = (a >= b);   // Not-borrow
      expFlags.v = (a[31] != b[31]) && (diff[31] != a[31]);

      findStore(32'h50, lowMask, foundLow);
      findStore(32'h54, highMask, foundHigh);
      if (!foundLow || !foundHigh)
      begin
         $display("%s: the condition accumulators were never stored", name);
         errorCount++;
      end
      else
      begin
         gotMask    = {17'b0, highMask[6:0], lowMask[7:0]};
         gotFlags.n = gotMask[4];   // MI
         gotFlags.z = gotMask[0];   // EQ
         gotFlags.c = gotMask[2];   // CS
         gotFlags.v = gotMask[6];   // VS
         checkWord(gotMask, {17'b0, expMask}, "condition mask");
         checkFlags(gotFlags, expFlags, "flags after SUBS");
      end
      checkStore(32'h58, diff, "SUBS difference");
      finishTest(name, startErr);
   endtask

   task automatic testBranch();
      int startErr;
      startErr = errorCount;
      beginTest();
      emitZero(0);
      emitDpImm(ALU_ADD, 1, 0, 8'hAA);   // Marker
      emitDpImm(ALU_ADD, 2, 0, 8'h33);
      emit(branchTo(COND_AL, 3, 6));
      emit(memAccess(1'b0, 1, 0, 12'h010));
      emit(memAccess(1'b0, 1, 0, 12'h014));
      emit(memAccess(1'b0, 2, 0, 12'h020));   // Branch target
      emit(dataProcReg(COND_AL, ALU_SUB, 1'b1, 3, 1, 1));   // Z set
      emit(branchTo(COND_NE, 8, 10));
      emit(memAccess(1'b0, 2, 0, 12'h024));   // Fall through
      emit(memAccess(1'b0, 2, 0, 12'hFC));
      runProgram("branching");
      foreach (storeDataQ[i])
         if (storeDataQ[i] == 32'hAA)
         begin
            $display("branching: marker stored at %h, skipped code ran", storeAddrQ[i]);
            errorCount++;
         end
      checkStore(32'h20, 32'h33, "store at branch target");
      checkStore(32'h24, 32'h33, "store after untaken BNE");
      finishTest("branching", startErr);
   endtask

   task automatic testRandom();
      int       startErr;
      aluOp_t   op;
      regAddr_t rd;
      regAddr_t rn;
      regAddr_t rm;
      word_t    imm;
      word_t    expQ [$];
      startErr = errorCount;
      beginTest();
      emitZero(0);
      for (int r = 1; r <= 8; r++)
      begin
         imm = randBits(8);
         emitDpImm(ALU_ADD, r, 0, imm[7:0]);
      end
      for (int i = 0; i < 20; i++)
      begin
         op = aluOp_t'(randBits(2));
         rd = regAddr_t'(1 + randBits(3));
         rn = regAddr_t'(1 + randBits(3));
         if (randBits(1) == 1)
         begin
            imm = randBits(8);
            emitDpImm(op, rd, rn, imm[7:0]);
         end
         else
         begin
            rm = regAddr_t'(1 + randBits(3));
            emitDpReg(op, rd, rn, rm);
         end
         expQ.push_back(regModel[rd]);
         emit(memAccess(1'b0, rd, 0, 12'(32'h100 + 4 * i)));
      end
      emit(memAccess(1'b0, 0, 0, 12'hFC));
      runProgram("random ops");
      foreach (expQ[i])
         checkStore(32'h100 + 4 * i, expQ[i], $sformatf("random op %0d", i));
      finishTest("random ops", startErr);
   endtask

   initial
   begin
      reset        = 1'b1;
      sentinelSeen = 1'b0;
      lfsr         = 32'haab2c840;
      progLen      = 0;
      errorCount   = 0;
      testCount    = 0;
      failedTests  = 0;
      for (int i = 0; i < 256; i++)
      begin
         instrMem[i] = {4'hF, 28'(i * 4)};
         dataMem[i]  = 32'(i) * 32'h9E37_79B1;
      end

      testArith();
      testLoadUse();
      testConditions(32'd5, 32'd5, "conditions equal");
      testConditions(32'd3, 32'd7, "conditions borrow");
      testConditions(32'h8000_0000, 32'd1, "conditions overflow");
      testConditions(32'h7FFF_FFFF, 32'hFFFF_FFFF, "conditions negative overflow");
      testConditions(randBits(32), randBits(32), "conditions random");
      testBranch();
      testRandom();

      $display("tests run: %0d, tests failed: %0d, check errors: %0d",
               testCount, failedTests, errorCount);
      if (errorCount == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: source/armCore.sv
/*
 * Pipelined ARMv4 subset core
 * Five stages with plain instruction and data memory ports
 */
module armCore import isaPkg::*; (
   input  logic  clk,
   input  logic  reset,
   output word_t pc,
   input  word_t instr,
   output logic  memWrite,
   output word_t aluOut,
   output word_t writeData,
   input  word_t readData
);

   word_t    instrD;
   logic     validD;
   word_t    pcPlus8;
   regAddr_t raD1;
   regAddr_t raD2;

   decExIf dx ();
   exMemIf xm ();
   wbIf    wb ();
   hazIf   haz ();

   fetchStage u_fetch (
      .clk     (clk),
      .reset   (reset),
      .haz     (haz),
      .instr   (instr),
      .pc      (pc),
      .instrD  (instrD),
      .validD  (validD),
      .pcPlus8 (pcPlus8)
   );

   decodeStage u_decode (
      .clk     (clk),
      .reset   (reset),
      .instrD  (instrD),
      .validD  (validD),
      .pcPlus8 (pcPlus8),
      .raD1    (raD1),
      .raD2    (raD2),
      .haz     (haz),
      .wb      (wb),
      .dx      (dx)
   );

   hazardUnit u_hazard (
      .haz  (haz),
      .dx   (dx),
      .xm   (xm),
      .wb   (wb),
      .raD1 (raD1),
      .raD2 (raD2)
   );

   executeStage u_execute (
      .clk   (clk),
      .reset (reset),
      .dx    (dx),
      .haz   (haz),
      .xm    (xm),
      .wb    (wb)
   );

   memWriteback u_memWb (
      .clk       (clk),
      .reset     (reset),
      .xm        (xm),
      .readData  (readData),
      .memWrite  (memWrite),
      .aluOut    (aluOut),
      .writeData (writeData),
      .wb        (wb)
   );

endmodule

// File: source/armCore_consts.svh
/*
 * Core constants for the pipelined ARM subset
 * Datapath widths, register count and program counter step
 */
`ifndef ARMCORE_CONSTS_SVH
`define ARMCORE_CONSTS_SVH

// Data and address width
`define ARM_DATA_W 32

// Register index width
`define ARM_REG_AW 4

// Physical registers, R15 is the PC
`define ARM_NUM_REGS 15
`define ARM_PC_REG 15

`define ARM_PC_STEP 4   // Bytes per instruction

`endif

// File: source/decodeStage.sv
/*
 * Decode stage
 * Control decode, immediate extension, register file and decode/execute register
 */
`include "armCore_consts.svh"

module decodeStage import isaPkg::*, pipePkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  word_t    instrD,
   input  logic     validD,
   input  word_t    pcPlus8,
   output regAddr_t raD1,
   output regAddr_t raD2,
   hazIf.decode     haz,
   wbIf.consumer    wb,
   decExIf.source   dx
);

   opClass_t  opClass;
   immSrc_t   immSrc;
   execCtrl_t ctrlD;
   logic      isStore;
   word_t     immExt;
   word_t     rd1;
   word_t     rd2;
   word_t     regs [`ARM_NUM_REGS];

   assign opClass = opClass_t'(instrD[27:26]);

   always_comb
   begin
      ctrlD      = '0;
      ctrlD.cond = cond_t'(instrD[31:28]);
      immSrc     = IMM8;
      isStore    = 1'b0;
      case (opClass)
         OP_DP:
         begin
            ctrlD.valid = 1'b1;
            case (instrD[24:21])
               4'b0100: ctrlD.aluOp = ALU_ADD;
               4'b0010: ctrlD.aluOp = ALU_SUB;
               4'b0000: ctrlD.aluOp = ALU_AND;
               4'b1100: ctrlD.aluOp = ALU_ORR;
               default: ctrlD.valid = 1'b0;   // Not in the subset
            endcase
            ctrlD.aluSrcImm = instrD[25];
            ctrlD.setNz     = instrD[20];
            ctrlD.setCv     = instrD[20] &
                              (ctrlD.aluOp == ALU_ADD || ctrlD.aluOp == ALU_SUB);
            ctrlD.regWrite  = 1'b1;
         end
         OP_MEM:
         begin
            // Immediate offset only, address is Rn plus offset
            ctrlD.valid     = ~instrD[25];
            immSrc          = IMM12;
            ctrlD.aluSrcImm = 1'b1;
            ctrlD.regWrite  = instrD[20];
            ctrlD.memToReg  = instrD[20];
            ctrlD.memWrite  = ~instrD[20];
            isStore         = ~instrD[20];
         end
         OP_BRANCH:
         begin
            ctrlD.valid     = instrD[25] & ~instrD[24];   // B only, no link
            immSrc          = IMM_BR24;
            ctrlD.aluSrcImm = 1'b1;
            ctrlD.branch    = 1'b1;
         end
         default: ;
      endcase
      ctrlD.valid = ctrlD.valid & validD & (instrD[31:28] != 4'b1111);
      if (instrD[15:12] == `ARM_PC_REG)
         ctrlD.regWrite = 1'b0;   // No PC writes from the datapath
   end

   // Branch target is built from R15, store data comes from Rd
   assign raD1 = ctrlD.branch ? regAddr_t'(`ARM_PC_REG) : instrD[19:16];
   assign raD2 = isStore ? instrD[15:12] : instrD[3:0];

   always_comb
   begin
      case (immSrc)
         IMM8:    immExt = {24'b0, instrD[7:0]};
         IMM12:   immExt = {20'b0, instrD[11:0]};
         default: immExt = {{6{instrD[23]}}, instrD[23:0], 2'b00};
      endcase
   end

   // Written mid-cycle so decode sees the writeback value
   always_ff @(negedge clk)
   begin
      if (wb.regWrite)
         regs[wb.wa3] <= wb.result;
   end

   assign rd1 = (raD1 == `ARM_PC_REG) ? pcPlus8 : regs[raD1];
   assign rd2 = (raD2 == `ARM_PC_REG) ? pcPlus8 : regs[raD2];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         dx.ctrl <= '0;
      else if (haz.flushE)
         dx.ctrl <= '0;   // Bubble into execute
      else
         dx.ctrl <= ctrlD;
   end

   always_ff @(posedge clk)
   begin
      dx.rd1 <= rd1;
      dx.rd2 <= rd2;
      dx.imm <= immExt;
      dx.ra1 <= raD1;
      dx.ra2 <= raD2;
      dx.wa3 <= instrD[15:12];
   end

endmodule

// File: source/executeStage.sv
/*
 * Execute stage
 * Forwarding, ALU, condition check, flags register and execute/memory register
 */
module executeStage import isaPkg::*, pipePkg::*; (
   input logic    clk,
   input logic    reset,
   decExIf.sink   dx,
   hazIf.execute  haz,
   exMemIf.source xm,
   wbIf.consumer  wb
);

   word_t       srcA;
   word_t       srcB;
   word_t       writeDataE;
   word_t       aluResult;
   logic [32:0] sum;
   logic        isSub;
   logic        isArith;
   logic        execOk;
   flags_t      flagsQ;
   flags_t      aluFlags;
   memCtrl_t    ctrlM;

   function automatic word_t fwdMux(logic [1:0] sel, word_t regVal);
      case (sel)
         2'b10:   return xm.aluOut;
         2'b01:   return wb.result;
         default: return regVal;
      endcase
   endfunction

   function automatic logic condCheck(cond_t cond, flags_t f);
      logic ge;
      ge = (f.n == f.v);
      case (cond)
         COND_EQ: return f.z;
         COND_NE: return ~f.z;
         COND_CS: return f.c;
         COND_CC: return ~f.c;
         COND_MI: return f.n;
         COND_PL: return ~f.n;
         COND_VS: return f.v;
         COND_VC: return ~f.v;
         COND_HI: return f.c & ~f.z;
         COND_LS: return ~f.c | f.z;
         COND_GE: return ge;
         COND_LT: return ~ge;
         COND_GT: return ~f.z & ge;
         COND_LE: return f.z | ~ge;
         COND_AL: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   assign srcA       = fwdMux(haz.forwardA, dx.rd1);
   assign writeDataE = fwdMux(haz.forwardB, dx.rd2);   // Also store data
   assign srcB       = dx.ctrl.aluSrcImm ? dx.imm : writeDataE;

   assign isSub   = (dx.ctrl.aluOp == ALU_SUB);
   assign isArith = (dx.ctrl.aluOp == ALU_ADD) || isSub;
   assign sum     = {1'b0, srcA} + {1'b0, isSub ? ~srcB : srcB} + {32'b0, isSub};

   always_comb
   begin
      case (dx.ctrl.aluOp)
         ALU_AND: aluResult = srcA & srcB;
         ALU_ORR: aluResult = srcA | srcB;
         default: aluResult = sum[31:0];
      endcase
   end

   assign aluFlags.n = aluResult[31];
   assign aluFlags.z = (aluResult == '0);
   assign aluFlags.c = isArith & sum[32];
   assign aluFlags.v = isArith & ~(srcA[31] ^ srcB[31] ^ isSub) & (srcA[31] ^ sum[31]);

   assign execOk = dx.ctrl.valid & condCheck(dx.ctrl.cond, flagsQ);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flagsQ <= '0;
      else if (execOk)
      begin
         if (dx.ctrl.setNz)
         begin
            flagsQ.n <= aluFlags.n;
            flagsQ.z <= aluFlags.z;
         end
         if (dx.ctrl.setCv)
         begin
            flagsQ.c <= aluFlags.c;
            flagsQ.v <= aluFlags.v;
         end
      end
   end

   // Branch target is R15 plus the scaled offset
   assign haz.branchTaken = execOk & dx.ctrl.branch;
   assign haz.target      = aluResult;

   always_comb
   begin
      ctrlM.valid    = dx.ctrl.valid;
      ctrlM.regWrite = execOk & dx.ctrl.regWrite;
      ctrlM.memWrite = execOk & dx.ctrl.memWrite;
      ctrlM.memToReg = dx.ctrl.memToReg;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         xm.ctrl <= '0;
      else
         xm.ctrl <= ctrlM;
   end

   always_ff @(posedge clk)
   begin
      xm.aluOut    <= aluResult;
      xm.writeData <= writeDataE;
      xm.wa3       <= dx.wa3;
   end

endmodule

// File: source/fetchStage.sv
/*
 * Fetch stage
 * PC register, next PC selection and the fetch/decode register
 */
`include "armCore_consts.svh"

module fetchStage import isaPkg::*; (
   input  logic  clk,
   input  logic  reset,
   hazIf.fetch   haz,
   input  word_t instr,
   output word_t pc,
   output word_t instrD,
   output logic  validD,
   output word_t pcPlus8
);

   // Sequential PC, also R15 for the instruction one step behind in decode
   assign pcPlus8 = pc + `ARM_PC_STEP;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= '0;
      else if (haz.branchTaken)
         pc <= haz.target;   // Resolved in execute
      else if (!haz.stallF)
         pc <= pcPlus8;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         validD <= 1'b0;
      else if (haz.flushD)
         validD <= 1'b0;
      else if (!haz.stallD)
         validD <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (!haz.stallD)
         instrD <= instr;
   end

endmodule

// File: source/hazardUnit.sv
/*
 * Hazard unit
 * Operand forwarding selects, load-use stall and branch flush
 */
module hazardUnit import isaPkg::*; (
   hazIf.control    haz,
   decExIf.observer dx,
   exMemIf.observer xm,
   wbIf.observer    wb,
   input regAddr_t  raD1,
   input regAddr_t  raD2
);

   logic loadUse;

   // Youngest producer wins
   function automatic logic [1:0] fwdSel(regAddr_t ra);
      if (xm.ctrl.regWrite && xm.wa3 == ra)
         return 2'b10;
      else if (wb.regWrite && wb.wa3 == ra)
         return 2'b01;
      else
         return 2'b00;
   endfunction

   assign haz.forwardA = fwdSel(dx.ra1);
   assign haz.forwardB = fwdSel(dx.ra2);

   // Load in execute feeding the instruction in decode
   assign loadUse = dx.ctrl.valid & dx.ctrl.memToReg &
                    ((dx.wa3 == raD1) | (dx.wa3 == raD2));

   assign haz.stallF = loadUse;
   assign haz.stallD = loadUse;
   assign haz.flushD = haz.branchTaken;
   assign haz.flushE = loadUse | haz.branchTaken;

endmodule

// File: source/isaPkg.sv
/*
 * ISA types for the ARMv4 subset
 * Opcode classes, ALU operations, condition codes and flags
 */
`include "armCore_consts.svh"

package isaPkg;

   typedef logic [`ARM_DATA_W-1:0] word_t;
   typedef logic [`ARM_REG_AW-1:0] regAddr_t;

   // Instr[27:26]
   typedef enum logic [1:0] {
      OP_DP     = 2'b00,
      OP_MEM    = 2'b01,
      OP_BRANCH = 2'b10
   } opClass_t;

   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,   // Carry is not-borrow
      ALU_AND = 2'b10,
      ALU_ORR = 2'b11
   } aluOp_t;

   // Instr[31:28], 4'b1111 is not part of the table
   typedef enum logic [3:0] {
      COND_EQ, COND_NE, COND_CS, COND_CC,
      COND_MI, COND_PL, COND_VS, COND_VC,
      COND_HI, COND_LS, COND_GE, COND_LT,
      COND_GT, COND_LE, COND_AL
   } cond_t;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

   typedef enum logic [1:0] {IMM8, IMM12, IMM_BR24} immSrc_t;

endpackage

// File: source/memWriteback.sv
/*
 * Memory and writeback stages
 * Drives the data memory and selects the register write result
 */
module memWriteback import isaPkg::*, pipePkg::*; (
   input  logic  clk,
   input  logic  reset,
   exMemIf.sink  xm,
   input  word_t readData,
   output logic  memWrite,
   output word_t aluOut,
   output word_t writeData,
   wbIf.source   wb
);

   memCtrl_t ctrlW;
   word_t    aluOutW;
   word_t    readDataW;
   regAddr_t wa3W;

   // Data memory answers in the same cycle
   assign memWrite  = xm.ctrl.valid & xm.ctrl.memWrite;
   assign aluOut    = xm.aluOut;
   assign writeData = xm.writeData;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         ctrlW <= '0;
      else
         ctrlW <= xm.ctrl;
   end

   always_ff @(posedge clk)
   begin
      aluOutW   <= xm.aluOut;
      readDataW <= readData;
      wa3W      <= xm.wa3;
   end

   assign wb.regWrite = ctrlW.valid & ctrlW.regWrite;
   assign wb.wa3      = wa3W;
   assign wb.result   = ctrlW.memToReg ? readDataW : aluOutW;   // Load data or ALU

endmodule

// File: source/pipePkg.sv
/*
 * Pipeline payload types
 * Control bundles carried by the execute and memory stage registers
 */
package pipePkg;

   import isaPkg::*;

   // Decode to execute
   typedef struct packed {
      logic   valid;
      cond_t  cond;
      aluOp_t aluOp;
      logic   aluSrcImm;   // Immediate as operand B
      logic   setNz;
      logic   setCv;
      logic   branch;
      logic   regWrite;
      logic   memWrite;
      logic   memToReg;
   } execCtrl_t;

   // Execute to memory, already gated by the condition
   typedef struct packed {
      logic valid;
      logic regWrite;
      logic memWrite;
      logic memToReg;
   } memCtrl_t;

endpackage

// File: source/stageIf.sv
/*
 * Stage interfaces
 * Pipeline register outputs, writeback path and hazard control
 */

// Decode/execute register contents
interface decExIf import isaPkg::*, pipePkg::*; ();
   execCtrl_t ctrl;
   word_t     rd1;
   word_t     rd2;
   word_t     imm;
   regAddr_t  ra1;
   regAddr_t  ra2;
   regAddr_t  wa3;

   modport source   (output ctrl, rd1, rd2, imm, ra1, ra2, wa3);
   modport sink     (input ctrl, rd1, rd2, imm, ra1, ra2, wa3);
   modport observer (input ctrl, ra1, ra2, wa3);
endinterface

// Execute/memory register contents
interface exMemIf import isaPkg::*, pipePkg::*; ();
   memCtrl_t ctrl;
   word_t    aluOut;
   word_t    writeData;
   regAddr_t wa3;

   modport source   (output ctrl, aluOut, writeData, wa3);
   modport sink     (input ctrl, aluOut, writeData, wa3);
   modport observer (input ctrl, wa3);
endinterface

// Register write from writeback
interface wbIf import isaPkg::*; ();
   logic     regWrite;
   regAddr_t wa3;
   word_t    result;

   modport source   (output regWrite, wa3, result);
   modport consumer (input regWrite, wa3, result);
   modport observer (input regWrite, wa3);
endinterface

interface hazIf import isaPkg::*; ();
   logic       stallF;
   logic       stallD;
   logic       flushD;
   logic       flushE;
   logic [1:0] forwardA;   // 10 memory, 01 writeback
   logic [1:0] forwardB;
   logic       branchTaken;
   word_t      target;

   modport control (output stallF, stallD, flushD, flushE, forwardA, forwardB,
                    input branchTaken);
   modport fetch   (input stallF, stallD, flushD, branchTaken, target);
   modport decode  (input flushE);
   modport execute (input forwardA, forwardB, output branchTaken, target);
endinterface
